// ==== cpu_golden.txt ====
# P word: program rom word in address order, hex
# T name: starts a test, W reg data: expected write-back in retire order, hex
# 0..4 adi, lhi, adi, add, nand
P 0045
P 34AB
P 00FD
P 12E0
P 24A8
# 5..8 back-to-back dependent arithmetic
P 0241
P 1270
P 13B8
P 2FC8
# 9..13 sw, lw with a direct consumer, sw then lw
P 5E04
P 4604
P 16E0
P 5301
P 4B01
# 14..19 beq not taken, beq taken over two dead slots
P 8703
P 0187
P 8A43
P 0081
P 00C1
P 0DC2
# 20..29 jal, jlr to 28, final self loop
P 9403
P 00C1
P 0101
P 015C
P AD40
P 0041
P 0081
P 00C1
P 15B8
P 8000
T alu_basic
W 1 0005
W 2 5580
W 3 FFFD
W 4 0002
W 5 AA7F
T forwarding
W 1 0006
W 6 000C
W 7 0012
W 1 FFED
T load_store
W 3 0012
W 4 0024
W 5 FFED
T branch
W 6 0007
W 7 0009
T jumps
W 2 0015
W 5 001C
W 6 0019
W 7 002E

// ==== cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and instruction word width
`define CPU_WORD_W 16

// register index width and bank size
`define CPU_REG_AW 3
`define CPU_NREGS 8

// data memory words, indexed by the low address bits
`define CPU_DMEM_DEPTH 256

`endif

// ==== cpu_top.sv ====
`default_nettype none
`include "cpu_settings.svh"

module cpu_top import isa_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`CPU_WORD_W-1:0] imem_data,
	output logic [`CPU_WORD_W-1:0] imem_addr,
	output logic                  wb_valid,
	output logic [`CPU_REG_AW-1:0] wb_addr,
	output logic [`CPU_WORD_W-1:0] wb_data
);

	// fetch to decode
	logic [`CPU_WORD_W-1:0] if_pc;
	instr_t if_instr;
	logic jal_redirect, ex_redirect, stall;
	logic [`CPU_WORD_W-1:0] jal_target, ex_target;

	// id/ex
	logic [`CPU_REG_AW-1:0] id_rs1, id_rs2, idex_rs1, idex_rs2, idex_rd;
	logic [`CPU_WORD_W-1:0] idex_pc, idex_va, idex_vb, idex_imm;
	logic [1:0] idex_alu_op;
	logic idex_reg_we, idex_mem_we, idex_mem_rd, idex_link, idex_beq, idex_jlr;

	// hazard view and ex/mem
	logic [`CPU_REG_AW-1:0] ex_rs1, ex_rs2, ex_rd, exm_rd;
	logic ex_reg_we, ex_mem_rd, exm_reg_we, exm_mem_we, exm_mem_rd;
	logic [`CPU_WORD_W-1:0] exm_result, exm_store_data;
	logic [1:0] fwd_a, fwd_b;

	fetch_stage u_fetch (
		.clk(clk), .arst_n(arst_n), .imem_data(imem_data), .stall(stall),
		.jal_redirect(jal_redirect), .jal_target(jal_target),
		.ex_redirect(ex_redirect), .ex_target(ex_target),
		.imem_addr(imem_addr), .if_pc(if_pc), .if_instr(if_instr)
	);

	decode_stage u_decode (
		.clk(clk), .arst_n(arst_n), .if_pc(if_pc), .if_instr(if_instr),
		.stall(stall), .ex_redirect(ex_redirect),
		.wb_we(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data),
		.jal_redirect(jal_redirect), .jal_target(jal_target),
		.id_rs1(id_rs1), .id_rs2(id_rs2),
		.pc(idex_pc), .rs1(idex_rs1), .rs2(idex_rs2), .rd(idex_rd),
		.va(idex_va), .vb(idex_vb), .imm(idex_imm), .alu_op(idex_alu_op),
		.reg_we(idex_reg_we), .mem_we(idex_mem_we), .mem_rd(idex_mem_rd),
		.link(idex_link), .is_beq(idex_beq), .is_jlr(idex_jlr)
	);

	execute_stage u_execute (
		.clk(clk), .arst_n(arst_n),
		.pc(idex_pc), .rs1(idex_rs1), .rs2(idex_rs2), .rd(idex_rd),
		.va(idex_va), .vb(idex_vb), .imm(idex_imm), .alu_op(idex_alu_op),
		.reg_we(idex_reg_we), .mem_we(idex_mem_we), .mem_rd(idex_mem_rd),
		.link(idex_link), .is_beq(idex_beq), .is_jlr(idex_jlr),
		.fwd_a(fwd_a), .fwd_b(fwd_b),
		.exmem_fwd_data(exm_result), .memwb_fwd_data(wb_data),
		.ex_redirect(ex_redirect), .ex_target(ex_target),
		.ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
		.ex_reg_we(ex_reg_we), .ex_mem_rd(ex_mem_rd),
		.exm_rd(exm_rd), .exm_reg_we(exm_reg_we), .exm_mem_we(exm_mem_we),
		.exm_mem_rd(exm_mem_rd), .exm_result(exm_result),
		.exm_store_data(exm_store_data)
	);

	mem_wb_stage u_mem_wb (
		.clk(clk), .arst_n(arst_n), .rd(exm_rd), .reg_we(exm_reg_we),
		.mem_we(exm_mem_we), .mem_rd(exm_mem_rd), .result(exm_result),
		.store_data(exm_store_data),
		.wb_we(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	hazard_unit u_hazard (
		.id_rs1(id_rs1), .id_rs2(id_rs2), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
		.ex_rd(ex_rd), .ex_reg_we(ex_reg_we), .ex_mem_rd(ex_mem_rd),
		.mem_rd_addr(exm_rd), .mem_reg_we(exm_reg_we),
		.wb_addr(wb_addr), .wb_we(wb_valid),
		.stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
	);

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`default_nettype none
`include "cpu_settings.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`CPU_WORD_W-1:0] if_pc,
	input  instr_t                if_instr,
	input  logic                  stall,
	input  logic                  ex_redirect,
	input  logic                  wb_we,
	input  logic [`CPU_REG_AW-1:0] wb_addr,
	input  logic [`CPU_WORD_W-1:0] wb_data,
	output logic                  jal_redirect,
	output logic [`CPU_WORD_W-1:0] jal_target,
	output logic [`CPU_REG_AW-1:0] id_rs1,
	output logic [`CPU_REG_AW-1:0] id_rs2,
	output logic [`CPU_WORD_W-1:0] pc,
	output logic [`CPU_REG_AW-1:0] rs1,
	output logic [`CPU_REG_AW-1:0] rs2,
	output logic [`CPU_REG_AW-1:0] rd,
	output logic [`CPU_WORD_W-1:0] va,
	output logic [`CPU_WORD_W-1:0] vb,
	output logic [`CPU_WORD_W-1:0] imm,
	output logic [1:0]            alu_op,
	output logic                  reg_we,
	output logic                  mem_we,
	output logic                  mem_rd,
	output logic                  link,
	output logic                  is_beq,
	output logic                  is_jlr
);

	logic [`CPU_WORD_W-1:0] rf_a, rf_b, d_imm, imm6_sx, imm9_sx;
	logic [`CPU_REG_AW-1:0] d_rd;
	logic [1:0] d_alu;
	logic d_we, d_mem_we, d_mem_rd, d_link, d_beq, d_jlr, d_jal, bubble;

	reg_file u_rf (
		.clk(clk), .arst_n(arst_n), .rs1(id_rs1), .rs2(id_rs2),
		.we(wb_we), .wa(wb_addr), .wd(wb_data), .rd1(rf_a), .rd2(rf_b)
	);

	assign imm6_sx = {{(`CPU_WORD_W-6){if_instr.i_fmt.imm6[5]}}, if_instr.i_fmt.imm6};
	assign imm9_sx = {{(`CPU_WORD_W-9){if_instr.j_fmt.imm9[8]}}, if_instr.j_fmt.imm9};

	// lhi value and pc+1 link both ride in imm, link selects it in execute
	always_comb begin
		id_rs1 = if_instr.r_fmt.ra;
		id_rs2 = if_instr.r_fmt.rb;
		d_rd = if_instr.r_fmt.ra;
		d_imm = imm6_sx;
		d_alu = ALU_ADD;
		{d_we, d_mem_we, d_mem_rd, d_link, d_beq, d_jlr, d_jal} = '0;
		case (if_instr.r_fmt.opcode)
			OP_ADI: begin
				d_rd = if_instr.i_fmt.rb;
				d_alu = ALU_ADDI;
				d_we = 1'b1;
			end
			OP_ADD, OP_NAND: begin
				d_rd = if_instr.r_fmt.rc;
				d_alu = (if_instr.r_fmt.opcode == OP_NAND) ? ALU_NAND : ALU_ADD;
				d_we = 1'b1;
			end
			OP_LHI: begin
				d_imm = {if_instr.j_fmt.imm9, 7'b0};
				d_link = 1'b1;
				d_we = 1'b1;
			end
			// base in rb, data register in ra
			OP_LW, OP_SW: begin
				id_rs1 = if_instr.i_fmt.rb;
				id_rs2 = if_instr.i_fmt.ra;
				d_alu = ALU_ADDI;
				d_we = (if_instr.r_fmt.opcode == OP_LW);
				d_mem_rd = (if_instr.r_fmt.opcode == OP_LW);
				d_mem_we = (if_instr.r_fmt.opcode == OP_SW);
			end
			OP_BEQ: d_beq = 1'b1;
			OP_JAL, OP_JLR: begin
				d_imm = if_pc + 1'b1;
				d_link = 1'b1;
				d_we = 1'b1;
				d_jal = (if_instr.r_fmt.opcode == OP_JAL);
				d_jlr = (if_instr.r_fmt.opcode == OP_JLR);
			end
			default: ;
		endcase
	end

	// jal waits out a stall and dies under an older redirect
	assign jal_redirect = d_jal && !stall && !ex_redirect;
	assign jal_target = if_pc + imm9_sx;
	assign bubble = stall || ex_redirect;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			{reg_we, mem_we, mem_rd, link, is_beq, is_jlr} <= '0;
		end else if (bubble) begin
			{reg_we, mem_we, mem_rd, link, is_beq, is_jlr} <= '0;
		end else begin
			{reg_we, mem_we, mem_rd, link, is_beq, is_jlr} <=
				{d_we, d_mem_we, d_mem_rd, d_link, d_beq, d_jlr};
		end
	end

	// id/ex payload, meaningless under a bubble
	always_ff @(posedge clk) begin
		pc <= if_pc;
		rs1 <= id_rs1;
		rs2 <= id_rs2;
		rd <= d_rd;
		va <= rf_a;
		vb <= rf_b;
		imm <= d_imm;
		alu_op <= d_alu;
	end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`default_nettype none
`include "cpu_settings.svh"

module execute_stage import pipe_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`CPU_WORD_W-1:0] pc,
	input  logic [`CPU_REG_AW-1:0] rs1,
	input  logic [`CPU_REG_AW-1:0] rs2,
	input  logic [`CPU_REG_AW-1:0] rd,
	input  logic [`CPU_WORD_W-1:0] va,
	input  logic [`CPU_WORD_W-1:0] vb,
	input  logic [`CPU_WORD_W-1:0] imm,
	input  logic [1:0]            alu_op,
	input  logic                  reg_we,
	input  logic                  mem_we,
	input  logic                  mem_rd,
	input  logic                  link,
	input  logic                  is_beq,
	input  logic                  is_jlr,
	input  logic [1:0]            fwd_a,
	input  logic [1:0]            fwd_b,
	input  logic [`CPU_WORD_W-1:0] exmem_fwd_data,
	input  logic [`CPU_WORD_W-1:0] memwb_fwd_data,
	output logic                  ex_redirect,
	output logic [`CPU_WORD_W-1:0] ex_target,
	output logic [`CPU_REG_AW-1:0] ex_rs1,
	output logic [`CPU_REG_AW-1:0] ex_rs2,
	output logic [`CPU_REG_AW-1:0] ex_rd,
	output logic                  ex_reg_we,
	output logic                  ex_mem_rd,
	output logic [`CPU_REG_AW-1:0] exm_rd,
	output logic                  exm_reg_we,
	output logic                  exm_mem_we,
	output logic                  exm_mem_rd,
	output logic [`CPU_WORD_W-1:0] exm_result,
	output logic [`CPU_WORD_W-1:0] exm_store_data
);

	logic [`CPU_WORD_W-1:0] op_a, op_b, alu_b, alu_out, result;

	function automatic logic [`CPU_WORD_W-1:0] fwd_pick(
		input logic [1:0] sel,
		input logic [`CPU_WORD_W-1:0] reg_val
	);
		case (sel)
			FWD_EXMEM: return exmem_fwd_data;
			FWD_MEMWB: return memwb_fwd_data;
			default:   return reg_val;
		endcase
	endfunction

	assign op_a = fwd_pick(fwd_a, va);
	assign op_b = fwd_pick(fwd_b, vb);

	// adi, lw and sw add the sign-extended offset
	assign alu_b = (alu_op == ALU_ADDI) ? imm : op_b;
	assign alu_out = (alu_op == ALU_NAND) ? ~(op_a & op_b) : op_a + alu_b;

	// lhi value or pc+1 link overrides the alu
	assign result = link ? imm : alu_out;

	// not-taken is the static guess, so only a taken beq or jlr redirects
	assign ex_redirect = is_jlr || (is_beq && op_a == op_b);
	assign ex_target = is_jlr ? op_b : pc + imm;

	// id/ex view for the hazard unit
	assign ex_rs1 = rs1;
	assign ex_rs2 = rs2;
	assign ex_rd = rd;
	assign ex_reg_we = reg_we;
	assign ex_mem_rd = mem_rd;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exm_reg_we <= 1'b0;
			exm_mem_we <= 1'b0;
			exm_mem_rd <= 1'b0;
		end else begin
			exm_reg_we <= reg_we;
			exm_mem_we <= mem_we;
			exm_mem_rd <= mem_rd;
		end
	end

	// store data is the forwarded ra of sw
	always_ff @(posedge clk) begin
		exm_rd <= rd;
		exm_result <= result;
		exm_store_data <= op_b;
	end

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
`default_nettype none
`include "cpu_settings.svh"

module fetch_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`CPU_WORD_W-1:0] imem_data,
	input  logic                  stall,
	input  logic                  jal_redirect,
	input  logic [`CPU_WORD_W-1:0] jal_target,
	input  logic                  ex_redirect,
	input  logic [`CPU_WORD_W-1:0] ex_target,
	output logic [`CPU_WORD_W-1:0] imem_addr,
	output logic [`CPU_WORD_W-1:0] if_pc,
	output instr_t                if_instr
);

	logic [`CPU_WORD_W-1:0] pc;
	logic [`CPU_WORD_W-1:0] next_pc;
	logic [1:0] pc_sel;
	logic flush;

	// execute redirect is older, so it wins over a jal in decode
	always_comb begin
		if (ex_redirect) begin
			pc_sel = PC_EX;
		end else if (jal_redirect) begin
			pc_sel = PC_JAL;
		end else begin
			pc_sel = PC_SEQ;
		end
	end

	always_comb begin
		case (pc_sel)
			PC_EX:   next_pc = ex_target;
			PC_JAL:  next_pc = jal_target;
			default: next_pc = pc + 1'b1;
		endcase
	end

	// any redirect kills the word fetched this cycle
	assign flush = (pc_sel != PC_SEQ);
	assign imem_addr = pc;

	// a redirect always moves the pc, a stall holds it otherwise
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
			if_instr <= NOP_WORD;
		end else if (flush) begin
			pc <= next_pc;
			if_instr <= NOP_WORD;
		end else if (!stall) begin
			pc <= next_pc;
			if_instr <= imem_data;
		end
	end

	// pc of the word held in if/id
	always_ff @(posedge clk) begin
		if (!stall) begin
			if_pc <= pc;
		end
	end

endmodule

`default_nettype wire

// ==== hazard_unit.sv ====
`default_nettype none
`include "cpu_settings.svh"

module hazard_unit import pipe_pkg::*; (
	input  logic [`CPU_REG_AW-1:0] id_rs1,
	input  logic [`CPU_REG_AW-1:0] id_rs2,
	input  logic [`CPU_REG_AW-1:0] ex_rs1,
	input  logic [`CPU_REG_AW-1:0] ex_rs2,
	input  logic [`CPU_REG_AW-1:0] ex_rd,
	input  logic                  ex_reg_we,
	input  logic                  ex_mem_rd,
	input  logic [`CPU_REG_AW-1:0] mem_rd_addr,
	input  logic                  mem_reg_we,
	input  logic [`CPU_REG_AW-1:0] wb_addr,
	input  logic                  wb_we,
	output logic                  stall,
	output logic [1:0]            fwd_a,
	output logic [1:0]            fwd_b
);

	// youngest producer first, ex/mem before mem/wb
	function automatic logic [1:0] pick_src(input logic [`CPU_REG_AW-1:0] src);
		if (mem_reg_we && mem_rd_addr == src) begin
			return FWD_EXMEM;
		end else if (wb_we && wb_addr == src) begin
			return FWD_MEMWB;
		end
		return FWD_REG;
	endfunction

	assign fwd_a = pick_src(ex_rs1);
	assign fwd_b = pick_src(ex_rs2);

	// load data only exists after mem, so a direct consumer waits one cycle
	assign stall = ex_mem_rd && ex_reg_we && (ex_rd == id_rs1 || ex_rd == id_rs2);

endmodule

`default_nettype wire

// ==== isa_pkg.sv ====
`default_nettype none
`include "cpu_settings.svh"

package isa_pkg;

	// one instruction word, three field layouts over the same bits
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [`CPU_REG_AW-1:0] ra;
			logic [`CPU_REG_AW-1:0] rb;
			logic [`CPU_REG_AW-1:0] rc;
			logic [2:0] spare;
		} r_fmt;
		struct packed {
			logic [3:0] opcode;
			logic [`CPU_REG_AW-1:0] ra;
			logic [`CPU_REG_AW-1:0] rb;
			logic [5:0] imm6;
		} i_fmt;
		struct packed {
			logic [3:0] opcode;
			logic [`CPU_REG_AW-1:0] ra;
			logic [8:0] imm9;
		} j_fmt;
	} instr_t;

	// opcodes, anything else retires as a nop
	localparam logic [3:0] OP_ADI  = 4'b0000;
	localparam logic [3:0] OP_ADD  = 4'b0001;
	localparam logic [3:0] OP_NAND = 4'b0010;
	localparam logic [3:0] OP_LHI  = 4'b0011;
	localparam logic [3:0] OP_LW   = 4'b0100;
	localparam logic [3:0] OP_SW   = 4'b0101;
	localparam logic [3:0] OP_BEQ  = 4'b1000;
	localparam logic [3:0] OP_JAL  = 4'b1001;
	localparam logic [3:0] OP_JLR  = 4'b1010;

endpackage

`default_nettype wire

// ==== mem_wb_stage.sv ====
`default_nettype none
`include "cpu_settings.svh"

module mem_wb_stage (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`CPU_REG_AW-1:0] rd,
	input  logic                  reg_we,
	input  logic                  mem_we,
	input  logic                  mem_rd,
	input  logic [`CPU_WORD_W-1:0] result,
	input  logic [`CPU_WORD_W-1:0] store_data,
	output logic                  wb_we,
	output logic [`CPU_REG_AW-1:0] wb_addr,
	output logic [`CPU_WORD_W-1:0] wb_data
);

	localparam int DMEM_AW = $clog2(`CPU_DMEM_DEPTH);

	logic [`CPU_WORD_W-1:0] dmem [`CPU_DMEM_DEPTH];
	logic [DMEM_AW-1:0] addr;
	logic [`CPU_WORD_W-1:0] load_data;

	// effective address wraps onto the low bits
	assign addr = result[DMEM_AW-1:0];
	assign load_data = dmem[addr];

	always_ff @(posedge clk) begin
		if (mem_we) begin
			dmem[addr] <= store_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_we <= 1'b0;
		end else begin
			wb_we <= reg_we;
		end
	end

	// mem/wb feeds the register file, forwarding and the trace port
	always_ff @(posedge clk) begin
		wb_addr <= rd;
		wb_data <= mem_rd ? load_data : result;
	end

endmodule

`default_nettype wire

// ==== pipe_pkg.sv ====
`default_nettype none
`include "cpu_settings.svh"

package pipe_pkg;

	// bubble word, opcode 0111 with all fields clear
	localparam logic [`CPU_WORD_W-1:0] NOP_WORD = 16'h7000;

	// operand source in execute
	localparam logic [1:0] FWD_REG   = 2'b00;
	localparam logic [1:0] FWD_EXMEM = 2'b01;
	localparam logic [1:0] FWD_MEMWB = 2'b10;

	// next-pc source in fetch
	localparam logic [1:0] PC_SEQ = 2'b00;
	localparam logic [1:0] PC_JAL = 2'b01;
	localparam logic [1:0] PC_EX  = 2'b10;

	// alu operation handed from decode to execute
	localparam logic [1:0] ALU_ADD  = 2'b00;
	localparam logic [1:0] ALU_ADDI = 2'b01;
	localparam logic [1:0] ALU_NAND = 2'b10;

endpackage

`default_nettype wire

// ==== project.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
reg_file.sv
hazard_unit.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
cpu_top.sv
tb_cpu.sv

// ==== reg_file.sv ====
`default_nettype none
`include "cpu_settings.svh"

module reg_file (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`CPU_REG_AW-1:0] rs1,
	input  logic [`CPU_REG_AW-1:0] rs2,
	input  logic                  we,
	input  logic [`CPU_REG_AW-1:0] wa,
	input  logic [`CPU_WORD_W-1:0] wd,
	output logic [`CPU_WORD_W-1:0] rd1,
	output logic [`CPU_WORD_W-1:0] rd2
);

	logic [`CPU_WORD_W-1:0] regs [`CPU_NREGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CPU_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wa] <= wd;
		end
	end

	// write-back in the same cycle shows up on the read ports
	assign rd1 = (we && wa == rs1) ? wd : regs[rs1];
	assign rd2 = (we && wa == rs2) ? wd : regs[rs2];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the cpu testbench with verilator, run it, decide from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_cpu -o tb_cpu
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== tb_cpu.sv ====
`default_nettype none
`include "cpu_settings.svh"

module tb_cpu;
	timeunit 1ns;
	timeprecision 100ps;

	// rom answer outside the program is opcode 0111 with clear fields
	localparam logic [`CPU_WORD_W-1:0] ROM_NOP = 16'h7000;
	localparam int ROM_DEPTH = 256;
	// quiet cycles watched after the last expected write
	localparam int SETTLE_CYCLES = 8;
	// word 0 is fetched in cycle 0 after release and retires four cycles later
	localparam int FIRST_RETIRE = 4;

	logic clk;
	logic arst_n;
	logic [`CPU_WORD_W-1:0] imem_addr;
	logic [`CPU_WORD_W-1:0] imem_data;
	logic wb_valid;
	logic [`CPU_REG_AW-1:0] wb_addr;
	logic [`CPU_WORD_W-1:0] wb_data;

	// program image and expected trace both come from the golden file
	logic [`CPU_WORD_W-1:0] rom [ROM_DEPTH];
	int prog_len;
	logic [`CPU_REG_AW-1:0] exp_addr [$];
	logic [`CPU_WORD_W-1:0] exp_data [$];
	string test_name [$];
	int test_first [$];
	int test_last [$];
	int test_errs [$];

	int wr_idx;
	int cur_test;
	int errors;
	int reset_errs;
	int n_fail;
	int cycles;
	int cycle_limit;
	bit checking;

	cpu_top UUT (
		.clk(clk), .arst_n(arst_n), .imem_data(imem_data), .imem_addr(imem_addr),
		.wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	// program rom answers in the same cycle
	assign imem_data = (imem_addr < prog_len) ? rom[imem_addr[7:0]] : ROM_NOP;

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// cycles since reset release bound the run
	always @(posedge clk) begin
		if (arst_n) begin
			cycles <= cycles + 1;
		end
	end

	// trace is sampled on the falling edge away from the update
	always @(negedge clk) begin
		if (checking && wb_valid) begin
			check_write();
		end
	end

	task automatic load_golden();
		int fd;
		int n;
		logic [8*32-1:0] tok;
		logic [8*128-1:0] rest;
		logic [`CPU_WORD_W-1:0] word;
		logic [`CPU_WORD_W-1:0] val;
		fd = $fopen("cpu_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open cpu_golden.txt, nothing to run");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			tok = '0;
			n = $fscanf(fd, "%s", tok);
			if (n != 1) begin
				break;
			end
			if (tok == "#") begin
				n = $fgets(rest, fd);
			end else if (tok == "P" && prog_len < ROM_DEPTH) begin
				n = $fscanf(fd, "%h", word);
				rom[prog_len] = word;
				prog_len++;
			end else if (tok == "T") begin
				tok = '0;
				n = $fscanf(fd, "%s", tok);
				test_name.push_back($sformatf("%0s", tok));
				test_first.push_back(exp_addr.size());
				test_last.push_back(exp_addr.size() - 1);
				test_errs.push_back(0);
			end else if (tok == "W" && test_name.size() > 0) begin
				n = $fscanf(fd, "%h %h", word, val);
				exp_addr.push_back(word[`CPU_REG_AW-1:0]);
				exp_data.push_back(val);
				test_last[test_last.size()-1] = exp_addr.size() - 1;
			end else begin
				$display("golden file holds an entry that makes no sense: %0s", tok);
				errors++;
			end
		end
		$fclose(fd);
	endtask

	task automatic note_error();
		errors++;
		if (cur_test < test_name.size()) begin
			test_errs[cur_test]++;
		end
	endtask

	task automatic report_test(input int i);
		int n_wr;
		n_wr = test_last[i] - test_first[i] + 1;
		$display("test %0s: %0d writes, %0d errors, %0s", test_name[i], n_wr,
			test_errs[i], (test_errs[i] == 0) ? "ok" : "failed");
	endtask

	// a test closes once its last expected write has been compared
	task automatic close_tests();
		while (cur_test < test_name.size() && test_last[cur_test] < wr_idx) begin
			report_test(cur_test);
			cur_test++;
		end
	endtask

	task automatic check_write();
		if (wr_idx >= exp_addr.size()) begin
			$display("write to r%0d of %h at %0t came after the last expected write",
				wb_addr, wb_data, $time);
			errors++;
		end else begin
			assert (wb_addr == exp_addr[wr_idx]) else begin
				$display("error at %0t: wb_addr is %0d, expected %0d", $time, wb_addr,
					exp_addr[wr_idx]);
				note_error();
			end
			assert (wb_data == exp_data[wr_idx]) else begin
				$display("error at %0t: wb_data is %h, expected %h", $time, wb_data,
					exp_data[wr_idx]);
				note_error();
			end
			wr_idx++;
			close_tests();
		end
	endtask

	// pc starts at zero and nothing retires yet
	task automatic check_reset(input string phase);
		assert (imem_addr == '0) else begin
			$display("error at %0t: imem_addr is %h %0s, expected 0000", $time,
				imem_addr, phase);
			reset_errs++;
		end
		assert (wb_valid == 1'b0) else begin
			$display("error at %0t: wb_valid is %b %0s, expected 0", $time, wb_valid, phase);
			reset_errs++;
		end
	endtask

	initial begin
		arst_n = 1'b0;
		checking = 1'b0;
		load_golden();
		if (exp_addr.size() == 0) begin
			$display("golden file gave no expected writes");
			errors++;
		end
		cycle_limit = 3 * prog_len + 20;

		// two rising edges pass inside reset
		@(posedge clk);
		@(negedge clk);
		check_reset("in reset");
		@(posedge clk);
		#1 arst_n = 1'b1;
		checking = 1'b1;
		@(negedge clk);
		check_reset("after release");

		// wb_valid must stay low until word 0 retires
		while (!wb_valid && cycles < cycle_limit) begin
			@(negedge clk);
		end
		assert (wb_valid && cycles == FIRST_RETIRE) else begin
			$display("wb_valid was low up to cycle %0d after reset release, expected cycle %0d",
				cycles, FIRST_RETIRE);
			reset_errs++;
		end
		errors += reset_errs;
		$display("test reset_state: %0d errors, %0s", reset_errs,
			(reset_errs == 0) ? "ok" : "failed");

		while (wr_idx < exp_addr.size() && cycles < cycle_limit) begin
			@(posedge clk);
		end

		if (wr_idx < exp_addr.size()) begin
			$display("timeout after %0d cycles, only %0d of %0d writes retired", cycles,
				wr_idx, exp_addr.size());
			for (int j = wr_idx; j < exp_addr.size(); j++) begin
				$display("write to r%0d of %h never retired", exp_addr[j], exp_data[j]);
				errors++;
			end
			for (int i = cur_test; i < test_name.size(); i++) begin
				test_errs[i]++;
				report_test(i);
			end
			cur_test = test_name.size();
		end else begin
			// stray writes from flushed slots would land here
			repeat (SETTLE_CYCLES) @(posedge clk);
		end

		n_fail = (reset_errs != 0) ? 1 : 0;
		foreach (test_errs[i]) begin
			if (test_errs[i] != 0) begin
				n_fail++;
			end
		end
		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			test_name.size() + 1, test_name.size() + 1 - n_fail, n_fail, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
